/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vdp_glue
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+include
verilog/vdp_bus_pkg.sv
verilog/vdp_av_pkg.sv
verilog/vdp_glue_ifs.sv
verilog/sync_pipe.sv
verilog/cpu_bus_port.sv
verilog/vram_sequencer.sv
verilog/av_output_stage.sv
verilog/vdp_glue_top.sv
verif/tb_vdp_glue.sv

/* include/vdp_glue_settings.svh */
`ifndef VDP_GLUE_SETTINGS_SVH
`define VDP_GLUE_SETTINGS_SVH

// address widths, vdp side and sdram side
`define VDP_VRAM_AW  17
`define VDP_MEM_AW   21

`define VDP_BYTE_W   8

// colour widths in and out
`define VDP_VIDEO_W  6
`define VDP_DVI_W    8

`define VDP_ADC_W    12
`define VDP_AUDIO_W  16  // one audio sample
`endif

/* verif/tb_vdp_glue.sv */
`timescale 1ns/1ps

module tb_vdp_glue;

    localparam int PULSE_REQ     = 0;
    localparam int PULSE_MEM     = 1;
    localparam int PULSE_REFRESH = 2;

    logic                      clk_w;
    logic                      reset_n_w;
    logic                      csr_n;
    logic                      csw_n;
    logic [1:0]                mode;
    vdp_bus_pkg::byte_t        cd_in;
    vdp_bus_pkg::byte_t        cd_out;
    logic                      cd_oe;
    vdp_bus_pkg::byte_t        vdp_dbi;
    logic                      vdp_req;
    logic                      vdp_wrt;
    vdp_bus_pkg::cpu_adr_t     vdp_adr;
    vdp_bus_pkg::byte_t        vdp_dbo;
    logic                      dl_clk;
    logic                      dh_clk;
    logic                      vram_we_n;
    logic                      vram_re_n;
    vdp_bus_pkg::vram_adr_t    vram_adr;
    vdp_bus_pkg::byte_t        vram_dbo;
    logic                      mem_busy;
    logic                      mem_read;
    logic                      mem_write;
    logic                      mem_refresh;
    vdp_bus_pkg::mem_adr_t     mem_addr;
    vdp_bus_pkg::mem_word_t    mem_din;
    vdp_bus_pkg::mem_mask_t    mem_wdm;
    logic                      scanline_en;
    logic                      line_odd;
    vdp_av_pkg::vdp_rgb_t      vdp_rgb;
    logic                      adc_valid;
    vdp_av_pkg::adc_word_t     adc_data;
    vdp_av_pkg::dvi_rgb_t      dvi_rgb;
    vdp_av_pkg::audio_sample_t sample_out;

    logic [31:0] lfsr_state;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    vdp_glue_top i_dut (.*);

    initial clk_w = 1'b0;
    always #20 clk_w = ~clk_w;  // 40 ns period

    // ------------------------------
    // concurrent checks
    // ------------------------------
    assert property (@(posedge clk_w) cd_oe == !csr_n)
        else begin
            $display("FAIL cd_oe: got %h expected %h", cd_oe, !csr_n);
            errors++;
        end

    assert property (@(posedge clk_w) cd_out == vdp_dbi)
        else begin
            $display("FAIL cd_out: got %h expected %h", cd_out, vdp_dbi);
            errors++;
        end

    assert property (@(posedge clk_w) disable iff (!reset_n_w) vdp_req |-> !$past(vdp_req))
        else begin
            $display("vdp_req stayed high for more than one cycle");
            errors++;
        end

    // controller busy in the previous cycle means no command now
    assert property (@(posedge clk_w) disable iff (!reset_n_w)
        $past(mem_busy) |-> !(mem_read || mem_write || mem_refresh))
        else begin
            $display("a memory command was issued while mem_busy was high");
            errors++;
        end

    assert property (@(posedge clk_w) disable iff (!reset_n_w)
        ($past(mem_read || mem_write, 2) && !$past(mem_busy, 2) && !$past(mem_busy))
        |-> mem_refresh)
        else begin
            $display("mem_refresh did not follow the access pulse after 2 cycles");
            errors++;
        end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random(input int bits, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < bits; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic bit pulse_now(input int which);
        case (which)
            PULSE_REQ: return vdp_req;
            PULSE_MEM: return mem_read || mem_write;
            default:   return mem_refresh;
        endcase
    endfunction

    task automatic wait_for_pulse(input int which, input string name, input int limit,
                                  output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk_w);
            cycles++;
            seen = pulse_now(which);
        end
        if (!seen) begin
            $display("timeout, no %s pulse within %0d cycles", name, limit);
            errors++;
        end
    endtask

    // no memory command may pulse for n cycles
    task automatic expect_quiet(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk_w);
            assert (!(mem_read || mem_write || mem_refresh)) else begin
                $display("a memory command pulsed while mem_busy was high");
                errors++;
            end
        end
    endtask

    // colour goes to the top 6 bits and one lower on a dimmed line
    function automatic vdp_av_pkg::dvi_rgb_t expect_dvi(input vdp_av_pkg::vdp_rgb_t p,
                                                        input logic half);
        int                   scale;
        vdp_av_pkg::dvi_rgb_t o;
        scale = half ? 2 : 4;
        o.r   = 8'(int'(p.r) * scale);
        o.g   = 8'(int'(p.g) * scale);
        o.b   = 8'(int'(p.b) * scale);
        return o;
    endfunction

    function automatic vdp_av_pkg::audio_sample_t expect_sample(input vdp_av_pkg::adc_word_t a);
        int v;
        v = (int'(a) / 4) * 16;  // top 10 bits over four zeros
        return 16'(v);
    endfunction

    task automatic report_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    // one vram access checked at its command pulse
    task automatic vram_access(input bit write, input bit high_lane);
        logic [31:0]            r;
        int                     cycles;
        vdp_bus_pkg::vram_adr_t adr;
        take_random(16, r);
        adr = {high_lane, r[15:0]};
        take_random(8, r);
        vram_adr  = adr;
        vram_dbo  = r[7:0];
        vram_we_n = !write;
        vram_re_n = write;
        dl_clk    = 1'b1;
        dh_clk    = 1'b1;
        wait_for_pulse(PULSE_MEM, "mem_read or mem_write", 6, cycles);
        dl_clk    = 1'b0;  // close the phase so no second access
        dh_clk    = 1'b0;
        vram_we_n = 1'b1;
        vram_re_n = 1'b1;
        compare_value("mem_write", 32'(mem_write), 32'(write));
        compare_value("mem_read", 32'(mem_read), 32'(!write));
        compare_value("mem_addr", 32'(mem_addr), 32'(adr) & 32'h0000_ffff);
        compare_value("mem_din", 32'(mem_din), 32'(vram_dbo) * 32'h101);
        compare_value("mem_wdm", 32'(mem_wdm), high_lane ? 32'h2 : 32'h1);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic write_request();
        int          errs_at_start;
        int          cycles;
        int          pass_no;
        int          i;
        logic [31:0] r;
        errs_at_start = errors;
        for (pass_no = 0; pass_no < 2; pass_no++) begin
            take_random(10, r);
            mode  = r[1:0];
            cd_in = r[9:2];
            csw_n = 1'b0;
            wait_for_pulse(PULSE_REQ, "vdp_req", 5, cycles);
            compare_value("vdp_wrt", 32'(vdp_wrt), 32'h1);
            compare_value("vdp_adr", 32'(vdp_adr), 32'(mode));
            compare_value("vdp_dbo", 32'(vdp_dbo), 32'(cd_in));
            for (i = 0; i < 8; i++) begin  // strobe still held
                @(negedge clk_w);
                assert (!vdp_req) else begin
                    $display("a second vdp_req came while csw_n was held low");
                    errors++;
                end
            end
            csw_n = 1'b1;
            repeat (6) @(negedge clk_w);
        end
        report_test("write request", errs_at_start);
    endtask

    task automatic read_request();
        int          errs_at_start;
        int          cycles;
        logic [31:0] r;
        errs_at_start = errors;
        take_random(18, r);
        mode    = r[1:0];
        cd_in   = r[9:2];
        vdp_dbi = r[17:10];
        csr_n   = 1'b0;
        wait_for_pulse(PULSE_REQ, "vdp_req", 5, cycles);
        compare_value("vdp_wrt", 32'(vdp_wrt), 32'h0);
        compare_value("vdp_adr", 32'(vdp_adr), 32'(mode));
        compare_value("cd_oe", 32'(cd_oe), 32'h1);
        compare_value("cd_out", 32'(cd_out), 32'(r[17:10]));
        take_random(8, r);
        vdp_dbi = r[7:0];
        @(negedge clk_w);
        compare_value("cd_out", 32'(cd_out), 32'(r[7:0]));
        csr_n = 1'b1;
        @(negedge clk_w);
        compare_value("cd_oe", 32'(cd_oe), 32'h0);
        repeat (6) @(negedge clk_w);
        report_test("read request", errs_at_start);
    endtask

    task automatic vram_mapping();
        int errs_at_start;
        int k;
        int cycles;
        errs_at_start = errors;
        for (k = 0; k < 4; k++) begin
            vram_access(k[0] == 1'b0, k[1]);
            wait_for_pulse(PULSE_REFRESH, "mem_refresh", 4, cycles);
            compare_value("refresh delay", 32'(cycles), 32'd2);
            repeat (2) @(negedge clk_w);
        end
        report_test("vram mapping", errs_at_start);
    endtask

    task automatic back_pressure();
        int errs_at_start;
        int cycles;
        errs_at_start = errors;
        mem_busy  = 1'b1;  // controller busy while the vdp phase is open
        dl_clk    = 1'b1;
        dh_clk    = 1'b1;
        vram_we_n = 1'b0;
        expect_quiet(6);
        mem_busy = 1'b0;
        vram_access(1'b1, 1'b0);  // held access goes out now
        mem_busy = 1'b1;
        expect_quiet(6);
        mem_busy = 1'b0;
        @(negedge clk_w);  // wait slot steps on to the refresh slot
        mem_busy = 1'b1;
        expect_quiet(4);
        mem_busy = 1'b0;
        wait_for_pulse(PULSE_REFRESH, "mem_refresh", 4, cycles);
        repeat (2) @(negedge clk_w);
        report_test("back-pressure", errs_at_start);
    endtask

    task automatic scanline_dimming();
        int          errs_at_start;
        int          combo;
        int          n;
        logic [31:0] r;
        errs_at_start = errors;
        for (combo = 0; combo < 4; combo++) begin
            for (n = 0; n < 4; n++) begin
                take_random(18, r);
                scanline_en = combo[0];
                line_odd    = combo[1];
                vdp_rgb     = vdp_av_pkg::vdp_rgb_t'(r[17:0]);
                @(negedge clk_w);
                compare_value("dvi_rgb", 32'(dvi_rgb),
                              32'(expect_dvi(vdp_rgb, scanline_en && line_odd)));
            end
        end
        report_test("scanline dimming", errs_at_start);
    endtask

    task automatic audio_capture();
        int                        errs_at_start;
        int                        n;
        int                        i;
        logic [31:0]               r;
        vdp_av_pkg::audio_sample_t old_sample;
        vdp_av_pkg::audio_sample_t new_sample;
        errs_at_start = errors;
        old_sample    = '0;  // nothing captured since reset
        for (n = 0; n < 4; n++) begin
            take_random(12, r);
            new_sample = expect_sample(r[11:0]);
            adc_data   = r[11:0];
            adc_valid  = 1'b1;
            for (i = 1; i <= 3; i++) begin
                @(negedge clk_w);
                adc_valid = 1'b0;
                compare_value("sample_out", 32'(sample_out),
                              32'((i < 3) ? old_sample : new_sample));
            end
            old_sample = new_sample;
        end
        report_test("audio capture", errs_at_start);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        lfsr_state  = 32'h6ba3;
        reset_n_w   = 1'b0;
        csr_n       = 1'b1;
        csw_n       = 1'b1;
        mode        = '0;
        cd_in       = '0;
        vdp_dbi     = '0;
        dl_clk      = 1'b0;
        dh_clk      = 1'b0;
        vram_we_n   = 1'b1;
        vram_re_n   = 1'b1;
        vram_adr    = '0;
        vram_dbo    = '0;
        mem_busy    = 1'b0;
        scanline_en = 1'b0;
        line_odd    = 1'b0;
        vdp_rgb     = '0;
        adc_valid   = 1'b0;
        adc_data    = '0;
        repeat (2) @(negedge clk_w);
        reset_n_w = 1'b1;
        repeat (2) @(negedge clk_w);
        write_request();
        read_request();
        vram_mapping();
        back_pressure();
        scanline_dimming();
        audio_capture();
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/av_output_stage.sv */
`timescale 1ns/1ps
`include "vdp_glue_settings.svh"

module av_output_stage (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    input  logic                      scanline_en,
    input  logic                      line_odd,
    input  vdp_av_pkg::vdp_rgb_t      vdp_rgb,
    input  logic                      adc_valid,
    input  vdp_av_pkg::adc_word_t     adc_data,
    output vdp_av_pkg::dvi_rgb_t      dvi_rgb,
    output vdp_av_pkg::audio_sample_t sample_out
);

    localparam int PAD_W = `VDP_DVI_W - `VDP_VIDEO_W;

    vdp_av_pkg::audio_sample_t sample_cap;
    logic                      dim;

    // widen one colour, halved on a dimmed line
    function automatic logic [`VDP_DVI_W-1:0] map_colour(
        input logic [`VDP_VIDEO_W-1:0] c,
        input logic                    half
    );
        if (half) return {1'b0, c, {(PAD_W-1){1'b0}}};
        return {c, {PAD_W{1'b0}}};
    endfunction

    assign dim = scanline_en && line_odd;

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            dvi_rgb    <= '0;
            sample_cap <= '0;
        end else begin
            dvi_rgb.r <= map_colour(vdp_rgb.r, dim);
            dvi_rgb.g <= map_colour(vdp_rgb.g, dim);
            dvi_rgb.b <= map_colour(vdp_rgb.b, dim);
            if (adc_valid) sample_cap <= {2'b00, adc_data[`VDP_ADC_W-1 -: 10], 4'b0000};
        end
    end

    // two more stages before the sample leaves
    sync_pipe #(
        .T           (vdp_av_pkg::audio_sample_t),
        .RESET_VALUE ('0)
    ) i_sample_pipe (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .d         (sample_cap),
        .q         (sample_out)
    );

endmodule

/* verilog/cpu_bus_port.sv */
`timescale 1ns/1ps

module cpu_bus_port (
    input  logic               clk_w,
    input  logic               reset_n_w,
    input  logic               csr_n,
    input  logic               csw_n,
    input  logic [1:0]         mode,
    input  vdp_bus_pkg::byte_t cd_in,
    cpu_req_if.port_side       req
);

    typedef enum logic {
        REQ_IDLE,
        REQ_WAIT  // request sent, wait for the strobes to move
    } req_state_e;

    localparam vdp_bus_pkg::cs_pair_t CS_IDLE = '{rd_n: 1'b1, wr_n: 1'b1};

    vdp_bus_pkg::cs_pair_t cs_raw;
    vdp_bus_pkg::cs_pair_t cs_sync;    // output of the synchronizer
    vdp_bus_pkg::cs_pair_t cs_sync_d;
    vdp_bus_pkg::cs_pair_t cs_hold;    // last agreed level
    vdp_bus_pkg::cs_pair_t cs_filt;
    vdp_bus_pkg::cs_pair_t cs_latch;   // pair seen when the request went out
    req_state_e            state;
    logic                  fire;

    assign cs_raw.rd_n = csr_n;
    assign cs_raw.wr_n = csw_n;

    sync_pipe #(
        .T           (vdp_bus_pkg::cs_pair_t),
        .RESET_VALUE (CS_IDLE)
    ) i_cs_sync (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .d         (cs_raw),
        .q         (cs_sync)
    );

    // ------------------------------
    // hysteresis, move only when both stages agree
    // ------------------------------
    always_comb begin
        cs_filt.rd_n = (cs_sync.rd_n == cs_sync_d.rd_n) ? cs_sync.rd_n : cs_hold.rd_n;
        cs_filt.wr_n = (cs_sync.wr_n == cs_sync_d.wr_n) ? cs_sync.wr_n : cs_hold.wr_n;
    end

    assign fire = (state == REQ_IDLE) && (cs_filt.rd_n ^ cs_filt.wr_n);  // exactly one strobe

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            cs_sync_d <= CS_IDLE;
            cs_hold   <= CS_IDLE;
            cs_latch  <= CS_IDLE;
            state     <= REQ_IDLE;
            req.req   <= 1'b0;
            req.wrt   <= 1'b0;
        end else begin
            cs_sync_d <= cs_sync;
            cs_hold   <= cs_filt;
            req.req   <= fire;
            if (fire) begin
                req.wrt  <= ~cs_filt.wr_n;
                cs_latch <= cs_filt;
                state    <= REQ_WAIT;
            end else if (state == REQ_WAIT && cs_filt != cs_latch) begin
                state <= REQ_IDLE;  // re-arm
            end
        end
    end

    always_ff @(posedge clk_w) begin
        if (fire) begin
            req.adr <= vdp_bus_pkg::cpu_adr_t'(mode);
            req.dbo <= cd_in;
        end
    end

endmodule

/* verilog/sync_pipe.sv */
`timescale 1ns/1ps

module sync_pipe #(
    parameter type T = logic,
    parameter T RESET_VALUE = '0
) (
    input  logic clk_w,
    input  logic reset_n_w,
    input  T     d,
    output T     q
);

    T stage1;  // first flop, may go metastable

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            stage1 <= RESET_VALUE;
            q      <= RESET_VALUE;
        end else begin
            stage1 <= d;
            q      <= stage1;
        end
    end

endmodule

/* verilog/vdp_av_pkg.sv */
`include "vdp_glue_settings.svh"

package vdp_av_pkg;

    // raw colour from the vdp core
    typedef struct packed {
        logic [`VDP_VIDEO_W-1:0] r;
        logic [`VDP_VIDEO_W-1:0] g;
        logic [`VDP_VIDEO_W-1:0] b;
    } vdp_rgb_t;

    typedef struct packed {
        logic [`VDP_DVI_W-1:0] r;
        logic [`VDP_DVI_W-1:0] g;
        logic [`VDP_DVI_W-1:0] b;
    } dvi_rgb_t;  // widened for the video encoder

    typedef logic [`VDP_ADC_W-1:0]   adc_word_t;
    typedef logic [`VDP_AUDIO_W-1:0] audio_sample_t;

endpackage

/* verilog/vdp_bus_pkg.sv */
`include "vdp_glue_settings.svh"

package vdp_bus_pkg;

    // ------------------------------
    // host and vdp core side
    // ------------------------------
    typedef logic [`VDP_BYTE_W-1:0]   byte_t;
    typedef logic [2*`VDP_BYTE_W-1:0] cpu_adr_t;  // only the mode bits are set

    // host strobes, both active low
    typedef struct packed {
        logic rd_n;
        logic wr_n;
    } cs_pair_t;

    typedef logic [`VDP_VRAM_AW-1:0] vram_adr_t;  // bit 16 picks the byte lane

    // ------------------------------
    // sdram command side
    // ------------------------------
    typedef logic [`VDP_MEM_AW-1:0]   mem_adr_t;
    typedef logic [2*`VDP_BYTE_W-1:0] mem_word_t;
    typedef logic [1:0]               mem_mask_t;  // high bit is the high byte

    typedef enum logic [1:0] {
        SLOT_ACCESS  = 2'd0,  // vram read or write goes out here
        SLOT_WAIT    = 2'd1,
        SLOT_REFRESH = 2'd2,
        SLOT_SETTLE  = 2'd3
    } vram_slot_e;

endpackage

/* verilog/vdp_glue_ifs.sv */
`timescale 1ns/1ps

// ------------------------------
// cpu request towards the vdp core
// ------------------------------
interface cpu_req_if;

    logic                  req;  // one-cycle strobe, no handshake
    logic                  wrt;  // 1 for a port write
    vdp_bus_pkg::cpu_adr_t adr;
    vdp_bus_pkg::byte_t    dbo;

    // wrt, adr and dbo qualify the same cycle as req
    modport port_side (output req, output wrt, output adr, output dbo);
    modport core_side (input req, input wrt, input adr, input dbo);

endinterface

// ------------------------------
// vram commands to the sdram controller
// ------------------------------
interface vram_cmd_if;

    logic                   read;     // pulses
    logic                   write;
    logic                   refresh;
    vdp_bus_pkg::mem_adr_t  addr;     // held from one access to the next
    vdp_bus_pkg::mem_word_t din;
    vdp_bus_pkg::mem_mask_t wdm;

    modport seq_side (
        output read, output write, output refresh,
        output addr, output din,   output wdm
    );

    modport mem_side (
        input read, input write, input refresh,
        input addr, input din,   input wdm
    );

endinterface

/* verilog/vdp_glue_top.sv */
`timescale 1ns/1ps

module vdp_glue_top (
    input  logic                      clk_w,
    input  logic                      reset_n_w,

    // host bus
    input  logic                      csr_n,
    input  logic                      csw_n,
    input  logic [1:0]                mode,
    input  vdp_bus_pkg::byte_t        cd_in,
    output vdp_bus_pkg::byte_t        cd_out,
    output logic                      cd_oe,

    // vdp core
    input  vdp_bus_pkg::byte_t        vdp_dbi,
    output logic                      vdp_req,
    output logic                      vdp_wrt,
    output vdp_bus_pkg::cpu_adr_t     vdp_adr,
    output vdp_bus_pkg::byte_t        vdp_dbo,
    input  logic                      dl_clk,
    input  logic                      dh_clk,
    input  logic                      vram_we_n,
    input  logic                      vram_re_n,
    input  vdp_bus_pkg::vram_adr_t    vram_adr,
    input  vdp_bus_pkg::byte_t        vram_dbo,

    // sdram controller
    input  logic                      mem_busy,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      mem_refresh,
    output vdp_bus_pkg::mem_adr_t     mem_addr,
    output vdp_bus_pkg::mem_word_t    mem_din,
    output vdp_bus_pkg::mem_mask_t    mem_wdm,

    // video and audio
    input  logic                      scanline_en,
    input  logic                      line_odd,
    input  vdp_av_pkg::vdp_rgb_t      vdp_rgb,
    input  logic                      adc_valid,
    input  vdp_av_pkg::adc_word_t     adc_data,
    output vdp_av_pkg::dvi_rgb_t      dvi_rgb,
    output vdp_av_pkg::audio_sample_t sample_out
);

    cpu_req_if  cpu_req ();
    vram_cmd_if vram_cmd ();

    // read data goes straight back while csr_n is low
    assign cd_oe  = ~csr_n;
    assign cd_out = vdp_dbi;

    cpu_bus_port i_cpu_bus_port (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .csr_n     (csr_n),
        .csw_n     (csw_n),
        .mode      (mode),
        .cd_in     (cd_in),
        .req       (cpu_req.port_side)
    );

    assign vdp_req = cpu_req.req;
    assign vdp_wrt = cpu_req.wrt;
    assign vdp_adr = cpu_req.adr;
    assign vdp_dbo = cpu_req.dbo;

    vram_sequencer i_vram_sequencer (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .dl_clk    (dl_clk),
        .dh_clk    (dh_clk),
        .vram_we_n (vram_we_n),
        .vram_re_n (vram_re_n),
        .vram_adr  (vram_adr),
        .vram_dbo  (vram_dbo),
        .mem_busy  (mem_busy),
        .cmd       (vram_cmd.seq_side)
    );

    assign mem_read    = vram_cmd.read;
    assign mem_write   = vram_cmd.write;
    assign mem_refresh = vram_cmd.refresh;
    assign mem_addr    = vram_cmd.addr;
    assign mem_din     = vram_cmd.din;
    assign mem_wdm     = vram_cmd.wdm;

    av_output_stage i_av_output_stage (
        .clk_w       (clk_w),
        .reset_n_w   (reset_n_w),
        .scanline_en (scanline_en),
        .line_odd    (line_odd),
        .vdp_rgb     (vdp_rgb),
        .adc_valid   (adc_valid),
        .adc_data    (adc_data),
        .dvi_rgb     (dvi_rgb),
        .sample_out  (sample_out)
    );

endmodule

/* verilog/vram_sequencer.sv */
`timescale 1ns/1ps

module vram_sequencer (
    input  logic                   clk_w,
    input  logic                   reset_n_w,
    input  logic                   dl_clk,
    input  logic                   dh_clk,
    input  logic                   vram_we_n,
    input  logic                   vram_re_n,
    input  vdp_bus_pkg::vram_adr_t vram_adr,
    input  vdp_bus_pkg::byte_t     vram_dbo,
    input  logic                   mem_busy,
    vram_cmd_if.seq_side           cmd
);

    vdp_bus_pkg::vram_slot_e slot;
    logic                    take_access;

    // vdp memory phase open and controller ready
    assign take_access = (slot == vdp_bus_pkg::SLOT_ACCESS) && dl_clk && dh_clk && !mem_busy;

    // ------------------------------
    // slot stepping and command pulses
    // ------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            slot        <= vdp_bus_pkg::SLOT_ACCESS;
            cmd.read    <= 1'b0;
            cmd.write   <= 1'b0;
            cmd.refresh <= 1'b0;
        end else begin
            cmd.read    <= 1'b0;
            cmd.write   <= 1'b0;
            cmd.refresh <= 1'b0;
            case (slot)
                vdp_bus_pkg::SLOT_ACCESS: begin
                    if (take_access) begin
                        cmd.write <= ~vram_we_n;
                        cmd.read  <= ~vram_re_n;
                        slot      <= vdp_bus_pkg::SLOT_WAIT;
                    end
                end
                vdp_bus_pkg::SLOT_WAIT: begin
                    if (!mem_busy) slot <= vdp_bus_pkg::SLOT_REFRESH;
                end
                vdp_bus_pkg::SLOT_REFRESH: begin
                    if (!mem_busy) begin
                        cmd.refresh <= 1'b1;  // on the way out of this slot
                        slot        <= vdp_bus_pkg::SLOT_SETTLE;
                    end
                end
                vdp_bus_pkg::SLOT_SETTLE: begin
                    if (!mem_busy) slot <= vdp_bus_pkg::SLOT_ACCESS;
                end
                default: slot <= vdp_bus_pkg::SLOT_ACCESS;
            endcase
        end
    end

    // ------------------------------
    // address and data for the access
    // ------------------------------
    always_ff @(posedge clk_w) begin
        if (take_access) begin
            cmd.addr <= vdp_bus_pkg::mem_adr_t'(vram_adr[15:0]);  // 16-bit word address
            cmd.din  <= {vram_dbo, vram_dbo};                     // byte on both lanes
            // bit 16 selects the lane to write
            cmd.wdm  <= {vram_adr[16], ~vram_adr[16]};
        end
    end

endmodule
